// File: Bender.yml
package:
  name: rv_pipe

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_pipe_pkg.sv
      - rv_regfile.sv
      - rv_fetch.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_mem_wb.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv

// File: rv_core.sv
`default_nettype none

module rv_core (
  input  logic                       clk,
  input  logic                       rst,
  output rv_isa_pkg::rv_word_t       pc_to_imem,
  input  rv_isa_pkg::rv_word_t       insn_from_imem,
  output rv_isa_pkg::rv_word_t       addr_to_dmem,
  input  rv_isa_pkg::rv_word_t       load_data_from_dmem,
  output logic                       halt,
  output rv_isa_pkg::rv_word_t       trace_writeback_pc,
  output rv_isa_pkg::rv_word_t       trace_writeback_insn,
  output rv_isa_pkg::rv_word_t       trace_writeback_rd_data,
  output rv_isa_pkg::rv_reg_idx_t    trace_writeback_rd,
  output logic                       trace_writeback_we,
  output rv_pipe_pkg::cycle_status_e trace_writeback_cycle_status
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  decode_state_t  decode_state;
  execute_state_t execute_state;
  memory_state_t  memory_state;

  logic        load_stall;
  logic        branch_taken;
  rv_word_t    branch_pc;
  rv_reg_idx_t rf_rs1;
  rv_reg_idx_t rf_rs2;
  rv_word_t    rs1_data;
  rv_word_t    rs2_data;
  rv_reg_idx_t mem_rd;
  rv_reg_idx_t wb_rd;
  rv_word_t    mem_rd_data;
  rv_word_t    wb_rd_data;
  logic        mem_we;
  logic        wb_we;

  rv_fetch u_fetch (
    .clk            (clk),
    .rst            (rst),
    .load_stall     (load_stall),
    .branch_taken   (branch_taken),
    .branch_pc      (branch_pc),
    .insn_from_imem (insn_from_imem),
    .pc_to_imem     (pc_to_imem),
    .decode_state   (decode_state)
  );

  rv_decode u_decode (
    .clk           (clk),
    .rst           (rst),
    .branch_taken  (branch_taken),
    .decode_state  (decode_state),
    .execute_state (execute_state),
    .load_stall    (load_stall)
  );

  rv_execute u_execute (
    .clk           (clk),
    .rst           (rst),
    .execute_state (execute_state),
    .rs1_data      (rs1_data),
    .rs2_data      (rs2_data),
    .mem_rd        (mem_rd),
    .wb_rd         (wb_rd),
    .mem_rd_data   (mem_rd_data),
    .wb_rd_data    (wb_rd_data),
    .mem_we        (mem_we),
    .wb_we         (wb_we),
    .rf_rs1        (rf_rs1),
    .rf_rs2        (rf_rs2),
    .branch_taken  (branch_taken),
    .branch_pc     (branch_pc),
    .memory_state  (memory_state)
  );

  rv_mem_wb u_mem_wb (
    .clk                          (clk),
    .rst                          (rst),
    .memory_state                 (memory_state),
    .load_data_from_dmem          (load_data_from_dmem),
    .addr_to_dmem                 (addr_to_dmem),
    .mem_rd                       (mem_rd),
    .wb_rd                        (wb_rd),
    .mem_rd_data                  (mem_rd_data),
    .wb_rd_data                   (wb_rd_data),
    .mem_we                       (mem_we),
    .wb_we                        (wb_we),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_rd_data      (trace_writeback_rd_data),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_we           (trace_writeback_we),
    .trace_writeback_cycle_status (trace_writeback_cycle_status)
  );

  // Execute reads, writeback writes through its forwarding pair
  rv_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rf_rs1),
    .rs2      (rf_rs2),
    .rd       (wb_rd),
    .we       (wb_we),
    .rd_data  (wb_rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

endmodule

`default_nettype wire

// File: rv_decode.sv
`default_nettype none

module rv_decode (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        branch_taken,
  input  rv_pipe_pkg::decode_state_t  decode_state,
  output rv_pipe_pkg::execute_state_t execute_state,
  output logic                        load_stall
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  rv_insn_u      d_insn;
  rv_word_t      d_imm_i_sext;
  rv_word_t      d_imm_b_sext;
  rv_insn_name_e d_name;

  assign d_insn = decode_state.insn;

  assign d_imm_i_sext = {{20{d_insn.i.imm12[11]}}, d_insn.i.imm12};
  // B immediate is scattered over the funct7 and rd fields
  assign d_imm_b_sext = {{20{d_insn.r.funct7[6]}}, d_insn.r.rd[0], d_insn.r.funct7[5:0],
                         d_insn.r.rd[4:1], 1'b0};

  always_comb begin
    d_name = INSN_NONE;
    case (d_insn.r.opcode)
      OP_LUI: d_name = INSN_LUI;
      OP_LOAD: begin
        if (d_insn.r.funct3 == 3'b010) d_name = INSN_LW;
      end
      OP_BRANCH: begin
        case (d_insn.r.funct3)
          3'b000:  d_name = INSN_BEQ;
          3'b001:  d_name = INSN_BNE;
          3'b100:  d_name = INSN_BLT;
          3'b101:  d_name = INSN_BGE;
          3'b110:  d_name = INSN_BLTU;
          3'b111:  d_name = INSN_BGEU;
          default: d_name = INSN_NONE;
        endcase
      end
      OP_REG_IMM: begin
        case (d_insn.r.funct3)
          3'b000: d_name = INSN_ADDI;
          3'b010: d_name = INSN_SLTI;
          3'b011: d_name = INSN_SLTIU;
          3'b100: d_name = INSN_XORI;
          3'b110: d_name = INSN_ORI;
          3'b111: d_name = INSN_ANDI;
          3'b001: if (d_insn.r.funct7 == 7'b000_0000) d_name = INSN_SLLI;
          3'b101: begin
            if (d_insn.r.funct7 == 7'b000_0000) d_name = INSN_SRLI;
            else if (d_insn.r.funct7 == 7'b010_0000) d_name = INSN_SRAI;
          end
          default: d_name = INSN_NONE;
        endcase
      end
      OP_REG_REG: begin
        case ({d_insn.r.funct7, d_insn.r.funct3})
          10'b0000000_000: d_name = INSN_ADD;
          10'b0100000_000: d_name = INSN_SUB;
          10'b0000000_001: d_name = INSN_SLL;
          10'b0000000_010: d_name = INSN_SLT;
          10'b0000000_011: d_name = INSN_SLTU;
          10'b0000000_100: d_name = INSN_XOR;
          10'b0000000_101: d_name = INSN_SRL;
          10'b0100000_101: d_name = INSN_SRA;
          10'b0000000_110: d_name = INSN_OR;
          10'b0000000_111: d_name = INSN_AND;
          default:         d_name = INSN_NONE;
        endcase
      end
      // ECALL has every field above the opcode at zero
      OP_ENVIRON: if (decode_state.insn[31:7] == '0) d_name = INSN_ECALL;
      default: d_name = INSN_NONE;
    endcase
  end

  // LW one stage ahead whose rd matches either source field
  assign load_stall = execute_state.insn_name == INSN_LW && execute_state.rd != '0 &&
                      (execute_state.rd == d_insn.r.rs1 || execute_state.rd == d_insn.r.rs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      execute_state <= '{status: CYCLE_RESET, insn_name: INSN_NONE, default: '0};
    end else if (branch_taken) begin
      execute_state <= '{status: CYCLE_TAKEN_BRANCH, insn_name: INSN_NONE, default: '0};
    end else if (load_stall) begin
      execute_state <= '{status: CYCLE_LOAD2USE, insn_name: INSN_NONE, default: '0};
    end else begin
      execute_state <= '{
        pc:         decode_state.pc,
        insn:       decode_state.insn,
        status:     decode_state.status,
        rs1:        d_insn.r.rs1,
        rs2:        d_insn.r.rs2,
        rd:         d_insn.r.rd,
        imm_u:      decode_state.insn[31:12],
        shamt:      d_insn.r.rs2,
        imm_i_sext: d_imm_i_sext,
        imm_b_sext: d_imm_b_sext,
        insn_name:  d_name
      };
    end
  end

endmodule

`default_nettype wire

// File: rv_execute.sv
`default_nettype none

module rv_execute (
  input  logic                        clk,
  input  logic                        rst,
  input  rv_pipe_pkg::execute_state_t execute_state,
  input  rv_isa_pkg::rv_word_t        rs1_data,
  input  rv_isa_pkg::rv_word_t        rs2_data,
  input  rv_isa_pkg::rv_reg_idx_t     mem_rd,
  input  rv_isa_pkg::rv_reg_idx_t     wb_rd,
  input  rv_isa_pkg::rv_word_t        mem_rd_data,
  input  rv_isa_pkg::rv_word_t        wb_rd_data,
  input  logic                        mem_we,
  input  logic                        wb_we,
  output rv_isa_pkg::rv_reg_idx_t     rf_rs1,
  output rv_isa_pkg::rv_reg_idx_t     rf_rs2,
  output logic                        branch_taken,
  output rv_isa_pkg::rv_word_t        branch_pc,
  output rv_pipe_pkg::memory_state_t  memory_state
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  rv_word_t x_a;
  rv_word_t x_b;
  rv_word_t x_rd_data;
  rv_word_t x_addr;
  logic     x_we;
  logic     x_load;
  logic     x_halt;

  assign rf_rs1 = execute_state.rs1;
  assign rf_rs2 = execute_state.rs2;

  // MX first, then WX, then the register file
  assign x_a = (rf_rs1 != '0 && rf_rs1 == mem_rd && mem_we) ? mem_rd_data :
               (rf_rs1 != '0 && rf_rs1 == wb_rd && wb_we)   ? wb_rd_data  : rs1_data;
  assign x_b = (rf_rs2 != '0 && rf_rs2 == mem_rd && mem_we) ? mem_rd_data :
               (rf_rs2 != '0 && rf_rs2 == wb_rd && wb_we)   ? wb_rd_data  : rs2_data;

  assign x_load = execute_state.insn_name == INSN_LW;
  assign x_halt = execute_state.insn_name == INSN_ECALL;
  assign x_addr = x_a + execute_state.imm_i_sext;

  assign branch_pc = execute_state.pc + execute_state.imm_b_sext;

  always_comb begin
    case (execute_state.insn_name)
      INSN_BEQ:  branch_taken = x_a == x_b;
      INSN_BNE:  branch_taken = x_a != x_b;
      INSN_BLT:  branch_taken = $signed(x_a) < $signed(x_b);
      INSN_BGE:  branch_taken = $signed(x_a) >= $signed(x_b);
      INSN_BLTU: branch_taken = x_a < x_b;
      INSN_BGEU: branch_taken = x_a >= x_b;
      default:   branch_taken = 1'b0;
    endcase
  end

  always_comb begin
    x_rd_data = '0;
    x_we      = 1'b1;
    case (execute_state.insn_name)
      INSN_LUI:   x_rd_data = {execute_state.imm_u, 12'b0};
      INSN_ADDI:  x_rd_data = x_a + execute_state.imm_i_sext;
      INSN_SLTI:  x_rd_data = {31'b0, $signed(x_a) < $signed(execute_state.imm_i_sext)};
      INSN_SLTIU: x_rd_data = {31'b0, x_a < execute_state.imm_i_sext};
      INSN_XORI:  x_rd_data = x_a ^ execute_state.imm_i_sext;
      INSN_ORI:   x_rd_data = x_a | execute_state.imm_i_sext;
      INSN_ANDI:  x_rd_data = x_a & execute_state.imm_i_sext;
      INSN_SLLI:  x_rd_data = x_a << execute_state.shamt;
      INSN_SRLI:  x_rd_data = x_a >> execute_state.shamt;
      INSN_SRAI:  x_rd_data = $signed(x_a) >>> execute_state.shamt;
      INSN_ADD:   x_rd_data = x_a + x_b;
      INSN_SUB:   x_rd_data = x_a - x_b;
      INSN_SLL:   x_rd_data = x_a << x_b[4:0];
      INSN_SLT:   x_rd_data = {31'b0, $signed(x_a) < $signed(x_b)};
      INSN_SLTU:  x_rd_data = {31'b0, x_a < x_b};
      INSN_XOR:   x_rd_data = x_a ^ x_b;
      INSN_SRL:   x_rd_data = x_a >> x_b[4:0];
      INSN_SRA:   x_rd_data = $signed(x_a) >>> x_b[4:0];
      INSN_OR:    x_rd_data = x_a | x_b;
      INSN_AND:   x_rd_data = x_a & x_b;
      // Loaded word is filled in by the memory stage
      INSN_LW:    x_rd_data = '0;
      // Branches, ECALL and bubbles write nothing
      default:    x_we = 1'b0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      memory_state <= '{status: CYCLE_RESET, default: '0};
    end else begin
      memory_state <= '{
        pc:        execute_state.pc,
        insn:      execute_state.insn,
        status:    execute_state.status,
        rd:        x_we ? execute_state.rd : '0,
        rd_data:   x_rd_data,
        is_load:   x_load,
        dmem_addr: x_addr,
        we:        x_we,
        halt:      x_halt
      };
    end
  end

endmodule

`default_nettype wire

// File: rv_fetch.sv
`default_nettype none

`include "rv_pipe_defs.svh"

module rv_fetch (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       load_stall,
  input  logic                       branch_taken,
  input  rv_isa_pkg::rv_word_t       branch_pc,
  input  rv_isa_pkg::rv_word_t       insn_from_imem,
  output rv_isa_pkg::rv_word_t       pc_to_imem,
  output rv_pipe_pkg::decode_state_t decode_state
);
  import rv_pipe_pkg::*;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_to_imem   <= `RV_RESET_PC;
      decode_state <= '{pc: '0, insn: '0, status: CYCLE_RESET};
    end else if (branch_taken) begin
      // Redirect and squash the instruction fetched this cycle
      pc_to_imem   <= branch_pc;
      decode_state <= '{pc: '0, insn: '0, status: CYCLE_TAKEN_BRANCH};
    end else if (load_stall) begin
      // Refetch the same PC, decode keeps its instruction
      pc_to_imem   <= pc_to_imem;
      decode_state <= decode_state;
    end else begin
      pc_to_imem   <= pc_to_imem + `RV_PC_STEP;
      decode_state <= '{pc: pc_to_imem, insn: insn_from_imem, status: CYCLE_NO_STALL};
    end
  end

endmodule

`default_nettype wire

// File: rv_isa_pkg.sv
`default_nettype none

`include "rv_pipe_defs.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] rv_word_t;
  typedef logic [`RV_REG_ADDR_W-1:0] rv_reg_idx_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OP_LOAD    = 7'b00_000_11,
    OP_BRANCH  = 7'b11_000_11,
    OP_REG_IMM = 7'b00_100_11,
    OP_REG_REG = 7'b01_100_11,
    OP_ENVIRON = 7'b11_100_11,
    OP_LUI     = 7'b01_101_11
  } rv_opcode_e;

  // Instruction names with INSN_NONE for anything not supported
  typedef enum logic [5:0] {
    INSN_NONE  = 6'd0,
    INSN_LUI   = 6'd1,
    INSN_BEQ   = 6'd5,
    INSN_BNE   = 6'd6,
    INSN_BLT   = 6'd7,
    INSN_BGE   = 6'd8,
    INSN_BLTU  = 6'd9,
    INSN_BGEU  = 6'd10,
    INSN_LW    = 6'd13,
    INSN_ADDI  = 6'd19,
    INSN_SLTI  = 6'd20,
    INSN_SLTIU = 6'd21,
    INSN_XORI  = 6'd22,
    INSN_ORI   = 6'd23,
    INSN_ANDI  = 6'd24,
    INSN_SLLI  = 6'd25,
    INSN_SRLI  = 6'd26,
    INSN_SRAI  = 6'd27,
    INSN_ADD   = 6'd28,
    INSN_SUB   = 6'd29,
    INSN_SLL   = 6'd30,
    INSN_SLT   = 6'd31,
    INSN_SLTU  = 6'd32,
    INSN_XOR   = 6'd33,
    INSN_SRL   = 6'd34,
    INSN_SRA   = 6'd35,
    INSN_OR    = 6'd36,
    INSN_AND   = 6'd37,
    INSN_ECALL = 6'd46
  } rv_insn_name_e;

  // Two views of one instruction word
  // r carries the register fields and funct7, i carries the 12-bit immediate
  typedef union packed {
    struct packed {
      logic [6:0]  funct7;
      rv_reg_idx_t rs2;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      rv_reg_idx_t rs1;
      logic [2:0]  funct3;
      rv_reg_idx_t rd;
      logic [6:0]  opcode;
    } i;
  } rv_insn_u;

endpackage

`default_nettype wire

// File: rv_mem_wb.sv
`default_nettype none

module rv_mem_wb (
  input  logic                       clk,
  input  logic                       rst,
  input  rv_pipe_pkg::memory_state_t memory_state,
  input  rv_isa_pkg::rv_word_t       load_data_from_dmem,
  output rv_isa_pkg::rv_word_t       addr_to_dmem,
  output rv_isa_pkg::rv_reg_idx_t    mem_rd,
  output rv_isa_pkg::rv_reg_idx_t    wb_rd,
  output rv_isa_pkg::rv_word_t       mem_rd_data,
  output rv_isa_pkg::rv_word_t       wb_rd_data,
  output logic                       mem_we,
  output logic                       wb_we,
  output logic                       halt,
  output rv_isa_pkg::rv_word_t       trace_writeback_pc,
  output rv_isa_pkg::rv_word_t       trace_writeback_insn,
  output rv_isa_pkg::rv_word_t       trace_writeback_rd_data,
  output rv_isa_pkg::rv_reg_idx_t    trace_writeback_rd,
  output logic                       trace_writeback_we,
  output rv_pipe_pkg::cycle_status_e trace_writeback_cycle_status
);
  import rv_pipe_pkg::*;

  writeback_state_t writeback_state;

  assign addr_to_dmem = memory_state.is_load ? memory_state.dmem_addr : '0;

  // Memory-stage forwarding pair already carries the loaded word
  assign mem_rd      = memory_state.rd;
  assign mem_rd_data = memory_state.is_load ? load_data_from_dmem : memory_state.rd_data;
  assign mem_we      = memory_state.we;

  always_ff @(posedge clk) begin
    if (rst) begin
      writeback_state <= '{status: CYCLE_RESET, default: '0};
    end else begin
      writeback_state <= '{
        pc:      memory_state.pc,
        insn:    memory_state.insn,
        status:  memory_state.status,
        rd:      memory_state.rd,
        rd_data: mem_rd_data,
        we:      memory_state.we,
        // Sticky until reset
        halt:    memory_state.halt | writeback_state.halt
      };
    end
  end

  assign wb_rd      = writeback_state.rd;
  assign wb_rd_data = writeback_state.rd_data;
  assign wb_we      = writeback_state.we;
  assign halt       = writeback_state.halt;

  assign trace_writeback_pc           = writeback_state.pc;
  assign trace_writeback_insn         = writeback_state.insn;
  assign trace_writeback_rd_data      = writeback_state.rd_data;
  assign trace_writeback_rd           = writeback_state.rd;
  assign trace_writeback_we           = writeback_state.we;
  assign trace_writeback_cycle_status = writeback_state.status;

endmodule

`default_nettype wire

// File: rv_pipe.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
rv_regfile.sv
rv_fetch.sv
rv_decode.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
tb_rv_core.sv

// File: rv_pipe_defs.svh
`ifndef RV_PIPE_DEFS_SVH
`define RV_PIPE_DEFS_SVH

// Data, address and PC width
`define RV_XLEN 32

// Register index width and register count
`define RV_REG_ADDR_W 5
`define RV_NUM_REGS 32

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Sequential fetch step in bytes
`define RV_PC_STEP 32'd4

`endif

// File: rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  // Classification of each cycle as seen in writeback
  typedef enum logic [3:0] {
    CYCLE_INVALID      = 4'd0,
    CYCLE_RESET        = 4'd1,
    CYCLE_NO_STALL     = 4'd2,
    CYCLE_TAKEN_BRANCH = 4'd4,
    CYCLE_LOAD2USE     = 4'd8
  } cycle_status_e;

  typedef struct packed {
    rv_isa_pkg::rv_word_t pc;
    rv_isa_pkg::rv_word_t insn;
    cycle_status_e        status;
  } decode_state_t;

  typedef struct packed {
    rv_isa_pkg::rv_word_t      pc;
    rv_isa_pkg::rv_word_t      insn;
    cycle_status_e             status;
    rv_isa_pkg::rv_reg_idx_t   rs1;
    rv_isa_pkg::rv_reg_idx_t   rs2;
    rv_isa_pkg::rv_reg_idx_t   rd;
    logic [19:0]               imm_u;
    logic [4:0]                shamt;
    rv_isa_pkg::rv_word_t      imm_i_sext;
    rv_isa_pkg::rv_word_t      imm_b_sext;
    rv_isa_pkg::rv_insn_name_e insn_name;
  } execute_state_t;

  typedef struct packed {
    rv_isa_pkg::rv_word_t    pc;
    rv_isa_pkg::rv_word_t    insn;
    cycle_status_e           status;
    rv_isa_pkg::rv_reg_idx_t rd;
    rv_isa_pkg::rv_word_t    rd_data;
    logic                    is_load;
    rv_isa_pkg::rv_word_t    dmem_addr;
    logic                    we;
    logic                    halt;
  } memory_state_t;

  typedef struct packed {
    rv_isa_pkg::rv_word_t    pc;
    rv_isa_pkg::rv_word_t    insn;
    cycle_status_e           status;
    rv_isa_pkg::rv_reg_idx_t rd;
    rv_isa_pkg::rv_word_t    rd_data;
    logic                    we;
    logic                    halt;
  } writeback_state_t;

endpackage

`default_nettype wire

// File: rv_regfile.sv
`default_nettype none

`include "rv_pipe_defs.svh"

module rv_regfile (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_isa_pkg::rv_reg_idx_t rs1,
  input  rv_isa_pkg::rv_reg_idx_t rs2,
  input  rv_isa_pkg::rv_reg_idx_t rd,
  input  logic                    we,
  input  rv_isa_pkg::rv_word_t    rd_data,
  output rv_isa_pkg::rv_word_t    rs1_data,
  output rv_isa_pkg::rv_word_t    rs2_data
);
  import rv_isa_pkg::*;

  // x0 has no storage
  rv_word_t regs [1:`RV_NUM_REGS-1];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

`default_nettype wire

// File: tb_rv_core.sv
`default_nettype none

`include "rv_pipe_defs.svh"

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int       IMEM_WORDS = 256;
  localparam int       DMEM_WORDS = 64;
  localparam rv_word_t ECALL_WORD = 32'h0000_0073;

  logic          clk;
  logic          rst;
  rv_word_t      pc_to_imem;
  rv_word_t      insn_from_imem;
  rv_word_t      addr_to_dmem;
  rv_word_t      load_data_from_dmem;
  logic          halt;
  rv_word_t      trace_writeback_pc;
  rv_word_t      trace_writeback_insn;
  rv_word_t      trace_writeback_rd_data;
  rv_reg_idx_t   trace_writeback_rd;
  logic          trace_writeback_we;
  cycle_status_e trace_writeback_cycle_status;

  rv_word_t imem [IMEM_WORDS];
  rv_word_t dmem [DMEM_WORDS];
  int       n_insn;

  // Architectural model
  rv_word_t model_regs [`RV_NUM_REGS];
  rv_word_t model_pc;

  integer seed;
  int     limit_cycles;

  // Both memories answer in the same cycle
  assign insn_from_imem      = imem[pc_to_imem[9:2]];
  assign load_data_from_dmem = dmem[addr_to_dmem[7:2]];

  rv_core u_dut (
    .clk                          (clk),
    .rst                          (rst),
    .pc_to_imem                   (pc_to_imem),
    .insn_from_imem               (insn_from_imem),
    .addr_to_dmem                 (addr_to_dmem),
    .load_data_from_dmem          (load_data_from_dmem),
    .halt                         (halt),
    .trace_writeback_pc           (trace_writeback_pc),
    .trace_writeback_insn         (trace_writeback_insn),
    .trace_writeback_rd_data      (trace_writeback_rd_data),
    .trace_writeback_rd           (trace_writeback_rd),
    .trace_writeback_we           (trace_writeback_we),
    .trace_writeback_cycle_status (trace_writeback_cycle_status)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic int pick(int n);
    return {$random(seed)} % n;
  endfunction

  function automatic rv_word_t rtype_word(logic [6:0] funct7, rv_reg_idx_t rs2,
                                          rv_reg_idx_t rs1, logic [2:0] funct3,
                                          rv_reg_idx_t rd);
    return {funct7, rs2, rs1, funct3, rd, OP_REG_REG};
  endfunction

  function automatic rv_word_t itype_word(logic [11:0] imm, rv_reg_idx_t rs1,
                                          logic [2:0] funct3, rv_reg_idx_t rd,
                                          rv_opcode_e op);
    return {imm, rs1, funct3, rd, op};
  endfunction

  function automatic rv_word_t btype_word(logic [12:0] off, rv_reg_idx_t rs2,
                                          rv_reg_idx_t rs1, logic [2:0] funct3);
    return {off[12], off[10:5], rs2, rs1, funct3, off[4:1], off[11], OP_BRANCH};
  endfunction

  task automatic emit(rv_word_t word);
    imem[n_insn] = word;
    n_insn++;
  endtask

  // Only registers x0..x7 so that neighbours depend on each other
  task automatic random_alu();
    rv_reg_idx_t rd;
    rv_reg_idx_t rs1;
    rv_reg_idx_t rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    rd  = 5'(pick(8));
    rs1 = 5'(pick(8));
    rs2 = 5'(pick(8));
    f3  = 3'(pick(8));
    f7  = 7'b000_0000;
    case (pick(3))
      0: emit({20'(pick(1 << 20)), rd, OP_LUI});
      1: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          if (f3 == 3'b101 && pick(2) == 1) begin
            f7 = 7'b010_0000;
          end
          emit(itype_word({f7, rs2}, rs1, f3, rd, OP_REG_IMM));
        end else begin
          emit(itype_word(12'(pick(4096)), rs1, f3, rd, OP_REG_IMM));
        end
      end
      default: begin
        if ((f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1) begin
          f7 = 7'b010_0000;
        end
        emit(rtype_word(f7, rs2, rs1, f3, rd));
      end
    endcase
  endtask

  task automatic build_program();
    logic [2:0]  branch_f3 [6];
    rv_reg_idx_t ra;
    rv_reg_idx_t rb;
    rv_reg_idx_t ld_rd;
    int          pos;
    int          neg;
    branch_f3 = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    // Unused words are NOPs tagged with their own word index
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = itype_word(12'(i), 5'd0, 3'b000, 5'd0, OP_REG_IMM);
    end
    n_insn = 0;
    for (int i = 0; i < 40; i++) begin
      random_alu();
    end
    // Equal, positive against negative and negative against positive operands
    for (int k = 0; k < 6; k++) begin
      for (int p = 0; p < 3; p++) begin
        ra  = 5'(1 + pick(7));
        rb  = 5'(1 + (ra % 7));
        pos = pick(1024);
        neg = -1 - pick(1024);
        emit(itype_word(12'((p == 2) ? neg : pos), 5'd0, 3'b000, ra, OP_REG_IMM));
        emit(itype_word(12'((p == 1) ? neg : pos), 5'd0, 3'b000, rb, OP_REG_IMM));
        // Taken target skips the next two words
        emit(btype_word(13'd12, rb, ra, branch_f3[k]));
        random_alu();
        random_alu();
      end
    end
    for (int j = 0; j < 8; j++) begin
      ra    = 5'(1 + pick(7));
      ld_rd = 5'(1 + pick(7));
      emit(itype_word(12'(4 * pick(32)), 5'd0, 3'b000, ra, OP_REG_IMM));
      emit(itype_word(12'(4 * pick(32)), ra, 3'b010, ld_rd, OP_LOAD));
      // Consumer reads the loaded register right away
      emit(rtype_word(7'b000_0000, 5'(pick(8)), ld_rd, 3'(pick(8)), 5'(pick(8))));
    end
    emit(ECALL_WORD);
  endtask

  task automatic reset_model();
    model_pc = `RV_RESET_PC;
    for (int r = 0; r < `RV_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
  endtask

  function automatic rv_word_t alu(logic [2:0] f3, logic alt, rv_word_t a, rv_word_t b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: begin
        if (alt) begin
          return $signed(a) >>> b[4:0];
        end else begin
          return a >> b[4:0];
        end
      end
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // One instruction at model_pc, and what writeback should show for it
  function automatic void ref_step(output rv_word_t pc, output rv_word_t insn,
                                   output rv_reg_idx_t rd, output rv_word_t data,
                                   output rv_word_t dmem_addr, output logic we,
                                   output logic is_halt, output int bubbles,
                                   output cycle_status_e bubble_status);
    rv_insn_u u;
    rv_insn_u nxt;
    rv_word_t w;
    rv_word_t a;
    rv_word_t b;
    rv_word_t imm_i;
    rv_word_t imm_b;
    rv_word_t addr;
    rv_word_t next_pc;
    logic     taken;
    u       = imem[model_pc[9:2]];
    w       = u;
    next_pc = model_pc + `RV_PC_STEP;
    nxt     = imem[next_pc[9:2]];
    a       = model_regs[u.r.rs1];
    b       = model_regs[u.r.rs2];
    imm_i   = {{20{u.i.imm12[11]}}, u.i.imm12};
    imm_b   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    addr    = a + imm_i;
    taken   = 1'b0;
    pc      = model_pc;
    insn    = w;
    data    = '0;
    dmem_addr = '0;
    we      = 1'b0;
    is_halt = 1'b0;
    bubbles = 0;
    bubble_status = CYCLE_NO_STALL;
    case (u.r.opcode)
      OP_LUI: begin
        we   = 1'b1;
        data = {w[31:12], 12'b0};
      end
      OP_REG_IMM: begin
        we   = 1'b1;
        data = alu(u.r.funct3, u.r.funct3 == 3'b101 && u.r.funct7[5], a, imm_i);
      end
      OP_REG_REG: begin
        we   = 1'b1;
        data = alu(u.r.funct3, u.r.funct7[5], a, b);
      end
      OP_LOAD: begin
        we        = 1'b1;
        dmem_addr = addr;
        data      = dmem[addr[7:2]];
        // Next word names the load target in a source field
        if (u.r.rd != '0 && (nxt.r.rs1 == u.r.rd || nxt.r.rs2 == u.r.rd)) begin
          bubbles       = 1;
          bubble_status = CYCLE_LOAD2USE;
        end
      end
      OP_BRANCH: begin
        case (u.r.funct3)
          3'b000:  taken = a == b;
          3'b001:  taken = a != b;
          3'b100:  taken = $signed(a) < $signed(b);
          3'b101:  taken = $signed(a) >= $signed(b);
          3'b110:  taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) begin
          bubbles       = 2;
          bubble_status = CYCLE_TAKEN_BRANCH;
        end
      end
      default: is_halt = u.r.opcode == OP_ENVIRON;
    endcase
    rd = we ? u.r.rd : '0;
    if (we && u.r.rd != '0) begin
      model_regs[u.r.rd] = data;
    end
    model_pc = taken ? model_pc + imm_b : next_pc;
  endfunction

  task automatic check_word(string name, rv_word_t got, rv_word_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_reg(string name, rv_reg_idx_t got, rv_reg_idx_t exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  task automatic check_status(string name, cycle_status_e got, cycle_status_e exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  initial begin : stimulus
    rv_word_t      d_pc;
    rv_word_t      d_insn;
    rv_reg_idx_t   d_rd;
    rv_word_t      d_data;
    rv_word_t      d_addr;
    logic          d_we;
    logic          d_halt;
    int            d_bubbles;
    cycle_status_e d_status;
    int            n;
    rst  = 1'b1;
    seed = 14110;
    for (int i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = $random(seed);
    end
    build_program();
    // Dry run of the model counts the commits up to ECALL
    reset_model();
    n      = 0;
    d_halt = 1'b0;
    while (!d_halt && n < 4 * IMEM_WORDS) begin
      ref_step(d_pc, d_insn, d_rd, d_data, d_addr, d_we, d_halt, d_bubbles, d_status);
      n++;
    end
    reset_model();
    limit_cycles = 16 + 4 + 4 * n + 8;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

  initial begin : compare
    rv_word_t      e_pc;
    rv_word_t      e_insn;
    rv_reg_idx_t   e_rd;
    rv_word_t      e_data;
    rv_word_t      e_addr;
    logic          e_we;
    logic          e_halt;
    int            pending;
    cycle_status_e pending_status;
    int            reset_left;
    rv_word_t      mem_addr;
    e_halt         = 1'b0;
    pending        = 0;
    pending_status = CYCLE_INVALID;
    reset_left     = 4;
    mem_addr       = '0;
    // Outputs are unknown until the first edge has reset them
    @(posedge clk);
    while (!e_halt) begin
      @(posedge clk);
      if (rst || reset_left > 0) begin
        if (!rst) begin
          reset_left--;
        end
        check_status("trace_writeback_cycle_status", trace_writeback_cycle_status, CYCLE_RESET);
        check_word("trace_writeback_pc", trace_writeback_pc, 32'h0);
        check_word("trace_writeback_insn", trace_writeback_insn, 32'h0);
        check_bit("trace_writeback_we", trace_writeback_we, 1'b0);
        check_bit("halt", halt, 1'b0);
      end else if (pending > 0) begin
        pending--;
        check_status("trace_writeback_cycle_status", trace_writeback_cycle_status,
                     pending_status);
        check_bit("trace_writeback_we", trace_writeback_we, 1'b0);
        check_bit("halt", halt, 1'b0);
      end else begin
        check_status("trace_writeback_cycle_status", trace_writeback_cycle_status,
                     CYCLE_NO_STALL);
        ref_step(e_pc, e_insn, e_rd, e_data, e_addr, e_we, e_halt, pending, pending_status);
        check_word("trace_writeback_pc", trace_writeback_pc, e_pc);
        check_word("trace_writeback_insn", trace_writeback_insn, e_insn);
        check_reg("trace_writeback_rd", trace_writeback_rd, e_rd);
        check_word("trace_writeback_rd_data", trace_writeback_rd_data, e_data);
        check_word("addr_to_dmem", mem_addr, e_addr);
        check_bit("trace_writeback_we", trace_writeback_we, e_we);
        check_bit("halt", halt, e_halt);
      end
      // The word now in memory reaches writeback one cycle later
      mem_addr = addr_to_dmem;
    end
    // Halt holds after the ECALL has left writeback
    @(posedge clk);
    check_bit("halt", halt, 1'b1);
    $display("TEST PASS");
    $finish;
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Timeout, halt was not seen within %0d cycles", limit_cycles);
    $display("TEST FAIL");
    $fatal(1, "timeout");
  end

endmodule

`default_nettype wire
